/* rtl/fir_pkg.sv */
// Audio FIR shared types
package fir_pkg;

    // Width of the Wishbone data bus.
    // It also sets the coefficient width.
    localparam int WB_DATA_W = 16;

    // Fraction bits of a Q2.14 coefficient.
    localparam int COEFF_FRAC = 14;

    // Default filter length.
    localparam int DEFAULT_TAPS = 16;

    // Default clock cycles between sample ticks.
    localparam int DEFAULT_SAMPLE_DIV = 64;

    // Signed 16-bit audio sample.
    typedef logic signed [15:0] sample_t;

    // Signed Q2.14 coefficient, as seen on the bus.
    typedef logic signed [WB_DATA_W-1:0] coeff_t;

    // Accumulator with headroom for 16 guard taps.
    typedef logic signed [35:0] acc_t;

endpackage

/* rtl/sample_strobe.sv */
// Audio sample tick generator
module sample_strobe #(
    parameter int SAMPLE_DIV = fir_pkg::DEFAULT_SAMPLE_DIV
) (
    input  logic clk,
    input  logic rst,
    output logic sample_tick
);

    // Down-counter wide enough for the reload value.
    localparam int CNT_W = $clog2(SAMPLE_DIV);
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(SAMPLE_DIV - 1);

    logic [CNT_W-1:0] cnt;

    // Tick is registered in the cycle the counter wraps.
    // The first one lands SAMPLE_DIV cycles after reset.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt         <= RELOAD;
            sample_tick <= 1'b0;
        end else begin
            if (cnt == '0) begin
                cnt         <= RELOAD;
                sample_tick <= 1'b1;
            end else begin
                cnt         <= cnt - 1'b1;
                sample_tick <= 1'b0;
            end
        end
    end

endmodule

/* rtl/coeff_memory.sv */
// Coefficient memory with Wishbone port
module coeff_memory #(
    parameter int NUM_TAPS = fir_pkg::DEFAULT_TAPS
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [$clog2(NUM_TAPS):0] wb_adr,
    input  fir_pkg::coeff_t        wb_dat_w,
    output fir_pkg::coeff_t        wb_dat_r,
    output logic                   wb_ack,
    input  logic [$clog2(NUM_TAPS):0] tap_index,
    output fir_pkg::coeff_t        tap_coeff
);

    // One extra address bit so addresses past the last tap decode as out of range.
    localparam int IDX_W = $clog2(NUM_TAPS);
    localparam int ADDR_W = IDX_W + 1;
    localparam logic [ADDR_W-1:0] TAP_LIMIT = ADDR_W'(NUM_TAPS);

    fir_pkg::coeff_t mem [NUM_TAPS];

    logic bus_req;
    logic adr_ok;
    logic tap_ok;

    // New request: strobe seen while no acknowledge is pending.
    assign bus_req = wb_cyc && wb_stb && !wb_ack;
    assign adr_ok  = wb_adr < TAP_LIMIT;
    assign tap_ok  = tap_index < TAP_LIMIT;

    // Single-cycle acknowledge, never stalls.
    // Writes land on the same edge as the acknowledge.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack <= 1'b0;
            mem    <= '{default: '0};
        end else begin
            wb_ack <= bus_req;
            if (bus_req && wb_we && adr_ok) begin
                mem[wb_adr[IDX_W-1:0]] <= wb_dat_w;
            end
        end
    end

    // Read data is valid during the acknowledge cycle.
    // Out of range reads give zero.
    always_ff @(posedge clk) begin
        if (bus_req && !wb_we) begin
            wb_dat_r <= adr_ok ? mem[wb_adr[IDX_W-1:0]] : '0;
        end
    end

    // Filter side read port, independent of bus traffic.
    assign tap_coeff = tap_ok ? mem[tap_index[IDX_W-1:0]] : '0;

endmodule

/* rtl/stereo_fir_core.sv */
// Stereo time-multiplexed FIR core
module stereo_fir_core #(
    parameter int NUM_TAPS = fir_pkg::DEFAULT_TAPS
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   sample_tick,
    input  fir_pkg::sample_t       l_in,
    input  fir_pkg::sample_t       r_in,
    output logic [$clog2(NUM_TAPS):0] tap_index,
    input  fir_pkg::coeff_t        tap_coeff,
    output fir_pkg::sample_t       l_out,
    output fir_pkg::sample_t       r_out,
    output logic                   out_valid
);

    // History pointer and tap index widths.
    localparam int IDX_W = $clog2(NUM_TAPS);
    localparam int ADDR_W = IDX_W + 1;
    localparam logic [IDX_W-1:0] LAST_PTR = IDX_W'(NUM_TAPS - 1);
    localparam logic [ADDR_W-1:0] LAST_TAP = ADDR_W'(NUM_TAPS - 1);

    // Accumulator bit positions for the output window.
    localparam int ACC_HI = $bits(fir_pkg::acc_t) - 1;
    localparam int SAT_HI = fir_pkg::COEFF_FRAC + $bits(fir_pkg::sample_t) - 1;

    // Sequencer stages.
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_MAC   = 2'd1;
    localparam logic [1:0] ST_FLUSH = 2'd2;
    localparam logic [1:0] ST_DONE  = 2'd3;

    // Circular history, one slot per tap.
    fir_pkg::sample_t hist_l [NUM_TAPS];
    fir_pkg::sample_t hist_r [NUM_TAPS];

    logic [IDX_W-1:0]  wr_ptr;
    logic [IDX_W-1:0]  rd_ptr;
    logic [ADDR_W-1:0] tap_cnt;
    logic [1:0]        stage;
    logic              phase;
    fir_pkg::coeff_t   coeff_r;
    logic signed [31:0] prod_l;
    logic signed [31:0] prod_r;
    fir_pkg::acc_t     acc_l;
    fir_pkg::acc_t     acc_r;

    // Pointer steps with wrap at the history depth.
    function automatic logic [IDX_W-1:0] ptr_next(input logic [IDX_W-1:0] p);
        return (p == LAST_PTR) ? '0 : p + 1'b1;
    endfunction

    function automatic logic [IDX_W-1:0] ptr_prev(input logic [IDX_W-1:0] p);
        return (p == '0) ? LAST_PTR : p - 1'b1;
    endfunction

    // Sign extension of a product into the accumulator.
    function automatic fir_pkg::acc_t ext(input logic signed [31:0] p);
        return {{(ACC_HI - 31){p[31]}}, p};
    endfunction

    // Keep the Q2.14 scaled window if the guard bits agree, else clamp.
    function automatic fir_pkg::sample_t sat(input fir_pkg::acc_t a);
        if (a[ACC_HI:SAT_HI] == {(ACC_HI - SAT_HI + 1){a[SAT_HI]}}) begin
            return a[SAT_HI:fir_pkg::COEFF_FRAC];
        end
        return {a[ACC_HI], {(SAT_HI - fir_pkg::COEFF_FRAC){~a[ACC_HI]}}};
    endfunction

    // Tap counter addresses the coefficient memory directly.
    assign tap_index = tap_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hist_l    <= '{default: '0};
            hist_r    <= '{default: '0};
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            tap_cnt   <= '0;
            stage     <= ST_IDLE;
            phase     <= 1'b0;
            coeff_r   <= '0;
            prod_l    <= '0;
            prod_r    <= '0;
            acc_l     <= '0;
            acc_r     <= '0;
            l_out     <= '0;
            r_out     <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            if (sample_tick) begin
                // Store the new pair and restart from the newest slot.
                hist_l[wr_ptr] <= l_in;
                hist_r[wr_ptr] <= r_in;
                rd_ptr  <= wr_ptr;
                wr_ptr  <= ptr_next(wr_ptr);
                tap_cnt <= '0;
                phase   <= 1'b0;
                stage   <= ST_MAC;
                prod_l  <= '0;
                prod_r  <= '0;
                acc_l   <= '0;
                acc_r   <= '0;
            end else begin
                case (stage)
                    ST_MAC: begin
                        if (!phase) begin
                            // Fetch phase.
                            coeff_r <= tap_coeff;
                            phase   <= 1'b1;
                        end else begin
                            // Multiply phase, previous product goes into the sum.
                            prod_l <= hist_l[rd_ptr] * coeff_r;
                            prod_r <= hist_r[rd_ptr] * coeff_r;
                            acc_l  <= acc_l + ext(prod_l);
                            acc_r  <= acc_r + ext(prod_r);
                            rd_ptr <= ptr_prev(rd_ptr);
                            phase  <= 1'b0;
                            if (tap_cnt == LAST_TAP) begin
                                stage <= ST_FLUSH;
                            end else begin
                                tap_cnt <= tap_cnt + 1'b1;
                            end
                        end
                    end
                    ST_FLUSH: begin
                        // Last product still in flight.
                        acc_l <= acc_l + ext(prod_l);
                        acc_r <= acc_r + ext(prod_r);
                        stage <= ST_DONE;
                    end
                    ST_DONE: begin
                        l_out     <= sat(acc_l);
                        r_out     <= sat(acc_r);
                        out_valid <= 1'b1;
                        stage     <= ST_IDLE;
                    end
                    default: begin
                        stage <= ST_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

/* rtl/audio_fir_top.sv */
// Stereo audio FIR subsystem
module audio_fir_top #(
    parameter int NUM_TAPS   = fir_pkg::DEFAULT_TAPS,
    parameter int SAMPLE_DIV = fir_pkg::DEFAULT_SAMPLE_DIV
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [$clog2(NUM_TAPS):0] wb_adr,
    input  fir_pkg::coeff_t        wb_dat_w,
    output fir_pkg::coeff_t        wb_dat_r,
    output logic                   wb_ack,
    input  fir_pkg::sample_t       l_in,
    input  fir_pkg::sample_t       r_in,
    output logic                   sample_tick,
    output fir_pkg::sample_t       l_out,
    output fir_pkg::sample_t       r_out,
    output logic                   out_valid
);

    // Tap address carries one spare bit for range decoding.
    localparam int ADDR_W = $clog2(NUM_TAPS) + 1;

    logic [ADDR_W-1:0] tap_index;
    fir_pkg::coeff_t   tap_coeff;

    // Audio rate.
    sample_strobe #(
        .SAMPLE_DIV (SAMPLE_DIV)
    ) strobe_i (
        .clk         (clk),
        .rst         (rst),
        .sample_tick (sample_tick)
    );

    // Host-visible coefficients.
    coeff_memory #(
        .NUM_TAPS (NUM_TAPS)
    ) coeff_mem_i (
        .clk       (clk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .tap_index (tap_index),
        .tap_coeff (tap_coeff)
    );

    // Filter datapath.
    stereo_fir_core #(
        .NUM_TAPS (NUM_TAPS)
    ) fir_core_i (
        .clk         (clk),
        .rst         (rst),
        .sample_tick (sample_tick),
        .l_in        (l_in),
        .r_in        (r_in),
        .tap_index   (tap_index),
        .tap_coeff   (tap_coeff),
        .l_out       (l_out),
        .r_out       (r_out),
        .out_valid   (out_valid)
    );

endmodule

/* verification/audio_fir_chk.sv */
// FIR subsystem protocol checks
module audio_fir_chk #(
    parameter int NUM_TAPS = fir_pkg::DEFAULT_TAPS
) (
    input logic clk,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic sample_tick,
    input logic out_valid
);

    // Edges from the capturing tick edge to the edge that sets out_valid.
    localparam int LATENCY = 2 * NUM_TAPS + 2;

    // Acknowledge is a single-cycle pulse.
    ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else $error("wb_ack high for two cycles in a row");

    // Acknowledge answers a request from the previous cycle.
    ack_after_req: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else $error("wb_ack without a preceding cyc and stb");

    // Result strobe is a single-cycle pulse.
    valid_single: assert property (@(posedge clk) disable iff (rst) out_valid |=> !out_valid)
        else $error("out_valid high for more than one cycle");

    // Tick is seen at its capture edge, out_valid one sample after the edge that sets it.
    valid_latency: assert property (@(posedge clk) disable iff (rst)
        sample_tick |-> ##(LATENCY + 1) out_valid)
        else $error("out_valid missing at the expected latency after sample_tick");

endmodule

bind audio_fir_top audio_fir_chk #(
    .NUM_TAPS (NUM_TAPS)
) chk_i (
    .clk         (clk),
    .rst         (rst),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_ack      (wb_ack),
    .sample_tick (sample_tick),
    .out_valid   (out_valid)
);

/* verification/audio_fir_tb.sv */
// Audio FIR directed testbench
module audio_fir_tb;

    localparam int NUM_TAPS      = 16;
    localparam int SAMPLE_DIV    = 64;
    localparam int ADDR_W        = $clog2(NUM_TAPS) + 1;
    localparam int CLK_PERIOD    = 100;
    localparam int DRIVE_DELAY   = 10;
    localparam int ACK_TIMEOUT   = 8;
    localparam int EVENT_TIMEOUT = 2 * SAMPLE_DIV;
    localparam int RUN_TIMEOUT   = 200 * SAMPLE_DIV;
    localparam fir_pkg::sample_t SAMPLE_MAX = 16'sh7fff;
    localparam fir_pkg::sample_t SAMPLE_MIN = 16'sh8000;

    logic              clk;
    logic              rst;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [ADDR_W-1:0] wb_adr;
    fir_pkg::coeff_t   wb_dat_w;
    fir_pkg::coeff_t   wb_dat_r;
    logic              wb_ack;
    fir_pkg::sample_t  l_in;
    fir_pkg::sample_t  r_in;
    logic              sample_tick;
    fir_pkg::sample_t  l_out;
    fir_pkg::sample_t  r_out;
    logic              out_valid;

    // Expected state: coefficients as written, input history newest first.
    fir_pkg::coeff_t  coeffs [NUM_TAPS];
    fir_pkg::sample_t hist_l [NUM_TAPS];
    fir_pkg::sample_t hist_r [NUM_TAPS];
    logic [31:0]      lcg_state;
    int               check_errors;
    int               timeout_errors;
    logic             tests_done;

    audio_fir_top #(
        .NUM_TAPS   (NUM_TAPS),
        .SAMPLE_DIV (SAMPLE_DIV)
    ) dut_i (
        .clk         (clk),
        .rst         (rst),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .l_in        (l_in),
        .r_in        (r_in),
        .sample_tick (sample_tick),
        .l_out       (l_out),
        .r_out       (r_out),
        .out_valid   (out_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // History follows every capture.
    // Inputs are stable at the falling edge of the tick cycle.
    always @(negedge clk) begin
        if (rst) begin
            for (int k = 0; k < NUM_TAPS; k++) begin
                hist_l[k] = '0;
                hist_r[k] = '0;
            end
        end else if (sample_tick) begin
            for (int k = NUM_TAPS - 1; k > 0; k--) begin
                hist_l[k] = hist_l[k - 1];
                hist_r[k] = hist_r[k - 1];
            end
            hist_l[0] = l_in;
            hist_r[0] = r_in;
        end
    end

    // Numerical Recipes LCG step.
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Upper half has the better randomness.
    function automatic logic [15:0] rand_half();
        logic [31:0] r;
        r = lcg_next();
        return r[31:16];
    endfunction

    // FIR sum in Q2.14, shifted back to sample scale, then clamped.
    function automatic fir_pkg::sample_t model_output(input bit right);
        fir_pkg::acc_t acc;
        fir_pkg::acc_t scaled;
        acc = '0;
        for (int k = 0; k < NUM_TAPS; k++) begin
            acc = acc + fir_pkg::acc_t'(coeffs[k])
                * fir_pkg::acc_t'(right ? hist_r[k] : hist_l[k]);
        end
        scaled = acc >>> fir_pkg::COEFF_FRAC;
        if (scaled > fir_pkg::acc_t'(SAMPLE_MAX)) return SAMPLE_MAX;
        if (scaled < fir_pkg::acc_t'(SAMPLE_MIN)) return SAMPLE_MIN;
        return fir_pkg::sample_t'(scaled);
    endfunction

    task automatic check_sample(input fir_pkg::sample_t got, input fir_pkg::sample_t exp,
                                input string what);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_coeff(input fir_pkg::coeff_t got, input fir_pkg::coeff_t exp,
                               input string what);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // Closing summary, then the verdict.
    task automatic end_run();
        $display("Errors: %0d failed checks, %0d timeouts", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    // A wait that gives up stops the test sequence here for good.
    task automatic report_timeout(input string what);
        timeout_errors++;
        $display("Timeout at %0t: %s never arrived", $time, what);
        forever @(posedge clk);
    endtask

    // One classic cycle; cyc and stb stay up until ack.
    task automatic wb_access(input bit we, input int addr, input fir_pkg::coeff_t data,
                             output fir_pkg::coeff_t rdata);
        int cycles;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = ADDR_W'(addr);
        wb_dat_w = data;
        cycles   = 0;
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
        end while (!wb_ack && cycles < ACK_TIMEOUT);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (!wb_ack) report_timeout("Wishbone acknowledge");
        else rdata = wb_dat_r;
    endtask

    task automatic wb_write(input int addr, input fir_pkg::coeff_t data);
        fir_pkg::coeff_t unused;
        wb_access(1'b1, addr, data, unused);
        // Out of range writes are dropped by the memory.
        if (addr < NUM_TAPS) coeffs[addr] = data;
    endtask

    task automatic wb_read(input int addr, output fir_pkg::coeff_t data);
        wb_access(1'b0, addr, '0, data);
    endtask

    // Returns one cycle after a tick, once the core has taken the inputs.
    task automatic wait_tick();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
        end while (!sample_tick && cycles < EVENT_TIMEOUT);
        if (!sample_tick) begin
            report_timeout("sample_tick");
        end else begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic wait_valid();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
        end while (!out_valid && cycles < EVENT_TIMEOUT);
        if (!out_valid) report_timeout("out_valid");
    endtask

    task automatic reset_state();
        rst = 1'b1;
        repeat (3) begin
            @(posedge clk);
            #DRIVE_DELAY;
            check_flag(out_valid, 1'b0, "out_valid in reset");
            check_flag(wb_ack, 1'b0, "wb_ack in reset");
            check_flag(sample_tick, 1'b0, "sample_tick in reset");
        end
        rst = 1'b0;
        @(posedge clk);
        #DRIVE_DELAY;
        check_flag(out_valid, 1'b0, "out_valid after reset");
        check_flag(wb_ack, 1'b0, "wb_ack after reset");
        check_flag(sample_tick, 1'b0, "sample_tick after reset");
        check_sample(l_out, 16'sd0, "l_out after reset");
        check_sample(r_out, 16'sd0, "r_out after reset");
        // Zero coefficients from reset must silence full-scale inputs.
        l_in = SAMPLE_MAX;
        r_in = SAMPLE_MIN;
        wait_tick();
        l_in = '0;
        r_in = '0;
        wait_valid();
        check_sample(l_out, 16'sd0, "first left result");
        check_sample(r_out, 16'sd0, "first right result");
    endtask

    task automatic coeff_bus();
        fir_pkg::coeff_t rd;
        for (int k = 0; k < NUM_TAPS; k++) begin
            wb_write(k, rand_half());
        end
        for (int k = 0; k < NUM_TAPS; k++) begin
            wb_read(k, rd);
            check_coeff(rd, coeffs[k], $sformatf("readback of tap %0d", k));
        end
        // Address 20 aliases no tap.
        wb_write(20, 16'sh1234);
        wb_read(20, rd);
        check_coeff(rd, 16'sd0, "read from address 20");
        wb_read(4, rd);
        check_coeff(rd, coeffs[4], "tap 4 after write to address 20");
    endtask

    task automatic impulse_response();
        for (int k = 0; k < NUM_TAPS; k++) begin
            wb_write(k, rand_half());
        end
        // Silence the whole history before the impulse.
        repeat (NUM_TAPS) wait_tick();
        // Unity impulse in Q2.14 scale.
        l_in = 16'sd16384;
        wait_tick();
        l_in = 16'sd0;
        for (int k = 0; k < NUM_TAPS; k++) begin
            wait_valid();
            check_sample(l_out, fir_pkg::sample_t'(coeffs[k]), $sformatf("impulse tap %0d", k));
            check_sample(r_out, 16'sd0, $sformatf("right channel at tap %0d", k));
        end
    endtask

    task automatic saturation();
        for (int k = 0; k < NUM_TAPS; k++) begin
            wb_write(k, 16'sh7fff);
        end
        l_in = SAMPLE_MAX;
        r_in = SAMPLE_MIN;
        // Fill the whole history with full-scale values.
        repeat (NUM_TAPS) wait_tick();
        wait_valid();
        check_sample(l_out, SAMPLE_MAX, "positive clamp");
        check_sample(r_out, SAMPLE_MIN, "negative clamp");
    endtask

    task automatic random_stream();
        fir_pkg::coeff_t c;
        for (int k = 0; k < NUM_TAPS; k++) begin
            c = $signed(rand_half()) >>> 3;
            wb_write(k, c);
        end
        wait_tick();
        for (int n = 0; n < 40; n++) begin
            l_in = rand_half();
            r_in = rand_half();
            wait_valid();
            check_sample(l_out, model_output(1'b0), $sformatf("left sample %0d", n));
            check_sample(r_out, model_output(1'b1), $sformatf("right sample %0d", n));
            wait_tick();
        end
    endtask

    // Directed tests in order, then the flag that closes the run.
    task automatic run_tests();
        reset_state();
        coeff_bus();
        impulse_response();
        saturation();
        random_stream();
        tests_done = 1'b1;
    endtask

    initial begin
        int cycles;
        clk            = 1'b0;
        rst            = 1'b1;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        wb_adr         = '0;
        wb_dat_w       = '0;
        l_in           = '0;
        r_in           = '0;
        lcg_state      = 32'h2bb2_7691;
        check_errors   = 0;
        timeout_errors = 0;
        tests_done     = 1'b0;
        for (int k = 0; k < NUM_TAPS; k++) begin
            coeffs[k] = '0;
        end
        fork
            run_tests();
        join_none
        // Watch for the end of the sequence or a wait that gave up.
        cycles = 0;
        while (!tests_done && timeout_errors == 0 && cycles < RUN_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!tests_done && timeout_errors == 0) begin
            timeout_errors++;
            $display("Timeout at %0t: test sequence did not finish", $time);
        end
        end_run();
    end

endmodule

/* all.f */
rtl/fir_pkg.sv
rtl/sample_strobe.sv
rtl/coeff_memory.sv
rtl/stereo_fir_core.sv
rtl/audio_fir_top.sv
verification/audio_fir_chk.sv
verification/audio_fir_tb.sv

/* build.sh */
#!/bin/sh
# Builds the audio FIR testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    --top-module audio_fir_tb \
    -f all.f \
    -o audio_fir_sim

# The run passes only if the testbench printed its pass line.
./obj_dir/audio_fir_sim | tee /dev/stderr | grep -x "All checks passed" > /dev/null
echo "Simulation passed"
